//--- files.f
hw/backend_pkg.sv
hw/execute_alu.sv
hw/ex_mem_register.sv
hw/load_store_unit.sv
hw/pipeline_control.sv
hw/writeback_stage.sv
hw/rv_backend.sv
test/clock_gen.sv
test/rv_backend_tb.sv

//--- Bender.yml
package:
  name: rv_backend

sources:
  - hw/backend_pkg.sv
  - hw/execute_alu.sv
  - hw/ex_mem_register.sv
  - hw/load_store_unit.sv
  - hw/pipeline_control.sv
  - hw/writeback_stage.sv
  - hw/rv_backend.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/rv_backend_tb.sv

//--- test/rv_backend_tb.sv
`timescale 1ns/1ps

module rv_backend_tb;

    localparam int XLEN       = 32;
    localparam int DMEM_DEPTH = 256;
    localparam int LOAD_WAIT  = 2;
    localparam int MEM_BYTES  = DMEM_DEPTH * 4;
    // reset bubbles, alu, wb sources, memory, load stall, drain
    localparam int NUM_INSTR      = 4 + 22 + 5 + 17 + 6 + 4;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (LOAD_WAIT + 3) + 50;

    logic                 clk, reset;
    logic [31:0]          ex_pc, ex_instruction, ex_rs1_data, ex_rs2_data;
    logic [31:0]          ex_imm, ex_csr_read_data;
    backend_pkg::alu_op_e ex_alu_op;
    backend_pkg::wb_sel_e ex_wb_select;
    logic                 ex_alu_src_imm, ex_memory_read, ex_memory_write;
    logic                 ex_register_write_enable;
    logic [2:0]           ex_funct3;
    logic [4:0]           ex_rd;
    logic                 stall, wb_write_enable;
    logic [4:0]           wb_rd;
    logic [31:0]          wb_data, wb_pc, wb_instruction;

    logic [31:0] lfsr_state  = 32'h4420;
    logic [31:0] next_pc     = 32'h0000_1000;
    int          seq         = 0;
    int          cycle_count = 0;  // rising edges so far
    int          stall_run   = 0;
    logic [7:0]  dmem_model [MEM_BYTES];
    logic [4:0]  exp_rd_q[$];
    logic [31:0] exp_data_q[$], exp_pc_q[$], exp_instr_q[$];
    int          exp_edge_q[$];

    clock_gen #(.PERIOD(10), .RESET_CYCLES(5)) i_clock_gen (.clk(clk), .reset(reset));

    rv_backend #(.XLEN(XLEN), .DMEM_DEPTH(DMEM_DEPTH), .LOAD_WAIT(LOAD_WAIT)) i_rv_backend (
        .clk(clk), .reset(reset), .ex_pc(ex_pc), .ex_instruction(ex_instruction),
        .ex_alu_op(ex_alu_op), .ex_alu_src_imm(ex_alu_src_imm),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data), .ex_imm(ex_imm),
        .ex_funct3(ex_funct3), .ex_rd(ex_rd), .ex_memory_read(ex_memory_read),
        .ex_memory_write(ex_memory_write),
        .ex_register_write_enable(ex_register_write_enable),
        .ex_wb_select(ex_wb_select), .ex_csr_read_data(ex_csr_read_data),
        .stall(stall), .wb_write_enable(wb_write_enable), .wb_rd(wb_rd),
        .wb_data(wb_data), .wb_pc(wb_pc), .wb_instruction(wb_instruction)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [4:0] nonzero_rd();
        logic [4:0] r;
        r = take_bits(5);
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    // rv32i result rules
    function automatic logic [31:0] alu_model(input backend_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        int          sh;
        sh = b[4:0];
        case (op)
            backend_pkg::ADD:  r = a + b;
            backend_pkg::SUB:  r = a - b;
            backend_pkg::SLL:  r = a << sh;
            backend_pkg::SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            backend_pkg::SLTU: r = {31'b0, a < b};
            backend_pkg::XOR:  r = a ^ b;
            backend_pkg::SRL:  r = a >> sh;
            backend_pkg::SRA: begin
                r = a >> sh;
                if (a[31]) r = r | ~(32'hFFFF_FFFF >> sh);  // refill sign bits
            end
            backend_pkg::OR:     r = a | b;
            backend_pkg::AND:    r = a & b;
            backend_pkg::PASS_B: r = b;
            default:             r = '0;
        endcase
        return r;
    endfunction

    task automatic clear_fields();
        ex_pc                    = next_pc;
        ex_instruction           = 32'h0000_0013;
        ex_alu_op                = backend_pkg::ADD;
        ex_alu_src_imm           = 1'b0;
        ex_rs1_data              = '0;
        ex_rs2_data              = '0;
        ex_imm                   = '0;
        ex_csr_read_data         = '0;
        ex_funct3                = 3'b000;
        ex_rd                    = 5'd0;
        ex_memory_read           = 1'b0;
        ex_memory_write          = 1'b0;
        ex_register_write_enable = 1'b0;
        ex_wb_select             = backend_pkg::WB_ALU;
    endtask

    // enter at a falling edge with fields set and leave one falling edge after capture
    task automatic issue(input logic [6:0] opcode, input logic [31:0] exp_data,
                         output int waited);
        int latency;
        latency        = ex_memory_read ? LOAD_WAIT + 1 : 1;
        ex_pc          = next_pc;
        ex_instruction = {seq[11:0], 13'h0, opcode};
        waited         = 0;
        while (stall) begin  // held at ID/EX
            waited++;
            @(negedge clk);
        end
        if (ex_register_write_enable && ex_rd != 5'd0) begin
            exp_rd_q.push_back(ex_rd);
            exp_data_q.push_back(exp_data);
            exp_pc_q.push_back(ex_pc);
            exp_instr_q.push_back(ex_instruction);
            exp_edge_q.push_back(cycle_count + 1 + latency);
        end
        seq++;
        next_pc += 4;
        @(negedge clk);
        clear_fields();
    endtask

    task automatic add_imm(output int waited);
        ex_rs1_data              = take_bits(32);
        ex_imm                   = take_bits(12);
        ex_alu_src_imm           = 1'b1;
        ex_rd                    = nonzero_rd();
        ex_register_write_enable = 1'b1;
        issue(7'h13, ex_rs1_data + ex_imm, waited);
    endtask

    task automatic store(input logic [2:0] funct3, input logic [31:0] addr,
                         input logic [31:0] data);
        int a;
        int waited;
        a               = addr % MEM_BYTES;
        ex_rs1_data     = addr & ~32'h7;
        ex_imm          = addr & 32'h7;
        ex_alu_src_imm  = 1'b1;
        ex_rs2_data     = data;
        ex_funct3       = funct3;
        ex_memory_write = 1'b1;
        if (funct3 == backend_pkg::SB) begin
            dmem_model[a] = data[7:0];
        end else if (funct3 == backend_pkg::SH) begin
            a = a & ~1;
            dmem_model[a]     = data[7:0];
            dmem_model[a + 1] = data[15:8];
        end else begin
            a = a & ~3;
            for (int i = 0; i < 4; i++) begin
                dmem_model[a + i] = data[8*i +: 8];
            end
        end
        issue(7'h23, '0, waited);
    endtask

    task automatic load(input logic [2:0] funct3, input logic [31:0] addr, output int waited);
        int          a;
        logic [31:0] expected;
        a = addr % MEM_BYTES;
        case (funct3)
            backend_pkg::LB:  expected = {{24{dmem_model[a][7]}}, dmem_model[a]};
            backend_pkg::LBU: expected = {24'h0, dmem_model[a]};
            backend_pkg::LH: begin
                a = a & ~1;
                expected = {{16{dmem_model[a + 1][7]}}, dmem_model[a + 1], dmem_model[a]};
            end
            backend_pkg::LHU: begin
                a = a & ~1;
                expected = {16'h0, dmem_model[a + 1], dmem_model[a]};
            end
            default: begin
                a = a & ~3;
                expected = {dmem_model[a + 3], dmem_model[a + 2],
                            dmem_model[a + 1], dmem_model[a]};
            end
        endcase
        ex_rs1_data              = addr & ~32'h7;
        ex_imm                   = addr & 32'h7;
        ex_alu_src_imm           = 1'b1;
        ex_funct3                = funct3;
        ex_memory_read           = 1'b1;
        ex_rd                    = nonzero_rd();
        ex_register_write_enable = 1'b1;
        ex_wb_select             = backend_pkg::WB_MEM;
        issue(7'h03, expected, waited);
    endtask

    task automatic reset_idle();
        int waited;
        @(negedge clk);
        check_value("stall", stall, 1'b0);
        check_value("wb_write_enable", wb_write_enable, 1'b0);
        check_value("wb_rd", wb_rd, 5'd0);
        check_value("wb_data", wb_data, '0);
        check_value("wb_pc", wb_pc, '0);
        wait (!reset);
        @(negedge clk);
        repeat (4) begin
            check_value("stall", stall, 1'b0);
            check_value("wb_write_enable", wb_write_enable, 1'b0);
            issue(7'h13, '0, waited);
        end
    endtask

    task automatic alu_sweep();
        logic [31:0] operand_b;
        logic [11:0] imm12;
        int          waited;
        for (int op = 0; op <= 10; op++) begin
            for (int src = 0; src < 2; src++) begin
                ex_alu_op                = backend_pkg::alu_op_e'(op);
                ex_alu_src_imm           = src[0];
                ex_rs1_data              = take_bits(32);
                ex_rs2_data              = take_bits(32);
                imm12                    = take_bits(12);
                ex_imm                   = {{20{imm12[11]}}, imm12};
                ex_rd                    = nonzero_rd();
                ex_register_write_enable = 1'b1;
                operand_b = src[0] ? ex_imm : ex_rs2_data;
                issue(src[0] ? 7'h13 : 7'h33, alu_model(ex_alu_op, ex_rs1_data, operand_b),
                      waited);
                check_value("alu stall cycles", waited, 0);
            end
        end
    endtask

    task automatic wb_source_select();
        int waited;
        ex_rs1_data              = take_bits(32);
        ex_rd                    = nonzero_rd();
        ex_register_write_enable = 1'b1;
        ex_wb_select             = backend_pkg::WB_PC4;
        issue(7'h6f, next_pc + 4, waited);  // link address
        ex_imm                   = take_bits(20) << 12;
        ex_rd                    = nonzero_rd();
        ex_register_write_enable = 1'b1;
        ex_wb_select             = backend_pkg::WB_IMM;
        issue(7'h37, ex_imm, waited);
        ex_csr_read_data         = take_bits(32);
        ex_rd                    = nonzero_rd();
        ex_register_write_enable = 1'b1;
        ex_wb_select             = backend_pkg::WB_CSR;
        issue(7'h73, ex_csr_read_data, waited);
        ex_rs1_data              = take_bits(32);
        ex_register_write_enable = 1'b1;  // x0 target gives no strobe
        issue(7'h13, ex_rs1_data, waited);
        add_imm(waited);
    endtask

    task automatic store_load_lanes();
        int waited;
        store(backend_pkg::SW, 32'h0000_0200, take_bits(32));
        store(backend_pkg::SW, 32'h0000_0204, take_bits(32));
        store(backend_pkg::SB, 32'h0000_0201, take_bits(32));
        store(backend_pkg::SB, 32'h0000_0207, take_bits(32) | 32'h80);  // negative byte
        store(backend_pkg::SH, 32'h0000_0202, take_bits(32));
        store(backend_pkg::SH, 32'h0000_0204, take_bits(32) | 32'h8000);
        load(backend_pkg::LB,  32'h0000_0201, waited);
        load(backend_pkg::LBU, 32'h0000_0201, waited);
        load(backend_pkg::LB,  32'h0000_0207, waited);
        load(backend_pkg::LBU, 32'h0000_0207, waited);
        load(backend_pkg::LH,  32'h0000_0202, waited);
        load(backend_pkg::LHU, 32'h0000_0202, waited);
        load(backend_pkg::LH,  32'h0000_0204, waited);
        load(backend_pkg::LHU, 32'h0000_0206, waited);
        load(backend_pkg::LW,  32'h0000_0200, waited);
        load(backend_pkg::LW,  32'h0000_0204, waited);
        load(backend_pkg::LW,  32'h0000_0208, waited);  // never written
    endtask

    task automatic load_stall_hold();
        int waited;
        store(backend_pkg::SW, 32'h0000_0300, take_bits(32));
        load(backend_pkg::LW, 32'h0000_0300, waited);
        add_imm(waited);
        check_value("stall cycles after load", waited, LOAD_WAIT);
        load(backend_pkg::LW, 32'h0000_0300, waited);
        load(backend_pkg::LH, 32'h0000_0302, waited);
        check_value("stall cycles after load", waited, LOAD_WAIT);
        add_imm(waited);
        check_value("stall cycles after load", waited, LOAD_WAIT);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            stall_run = 0;
        end else if (stall) begin
            stall_run++;
        end else if (stall_run != 0) begin
            check_value("stall run length", stall_run, LOAD_WAIT);
            stall_run = 0;
        end
    end

    // retirement in program order at the expected edge
    always @(negedge clk) begin
        if (!reset && wb_write_enable) begin
            if (exp_rd_q.size() == 0) begin
                abort_run("write strobe seen with no instruction due to retire");
            end else begin
                check_value("wb_rd", wb_rd, exp_rd_q.pop_front());
                check_value("wb_data", wb_data, exp_data_q.pop_front());
                check_value("wb_pc", wb_pc, exp_pc_q.pop_front());
                check_value("wb_instruction", wb_instruction, exp_instr_q.pop_front());
                check_value("retire edge", cycle_count, exp_edge_q.pop_front());
            end
        end
    end

    initial begin
        int waited;
        clear_fields();
        for (int i = 0; i < MEM_BYTES; i++) begin
            dmem_model[i] = 8'h00;
        end
        reset_idle();
        alu_sweep();
        wb_source_select();
        store_load_lanes();
        load_stall_hold();
        repeat (4) issue(7'h13, '0, waited);  // drain
        if (exp_rd_q.size() != 0) begin
            abort_run($sformatf("%0d expected writebacks never retired", exp_rd_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
)(
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- hw/rv_backend.sv
`timescale 1ns/1ps

module rv_backend #(
    parameter int XLEN       = 32,
    parameter int DMEM_DEPTH = 256,
    parameter int LOAD_WAIT  = 2
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [XLEN-1:0]      ex_pc,
    input  logic [31:0]          ex_instruction,
    input  backend_pkg::alu_op_e ex_alu_op,
    input  logic                 ex_alu_src_imm,
    input  logic [XLEN-1:0]      ex_rs1_data,
    input  logic [XLEN-1:0]      ex_rs2_data,
    input  logic [XLEN-1:0]      ex_imm,
    input  logic [2:0]           ex_funct3,
    input  logic [4:0]           ex_rd,
    input  logic                 ex_memory_read,
    input  logic                 ex_memory_write,
    input  logic                 ex_register_write_enable,
    input  backend_pkg::wb_sel_e ex_wb_select,
    input  logic [XLEN-1:0]      ex_csr_read_data,
    output logic                 stall,  // holds ID/EX too
    output logic                 wb_write_enable,
    output logic [4:0]           wb_rd,
    output logic [XLEN-1:0]      wb_data,
    output logic [XLEN-1:0]      wb_pc,
    output logic [31:0]          wb_instruction
);

    logic [XLEN-1:0]      alu_result, pc_plus_4, load_data;
    logic [XLEN-1:0]      mem_pc, mem_pc_plus_4, mem_read_data2, mem_imm;
    logic [XLEN-1:0]      mem_csr_read_data, mem_alu_result;
    logic [31:0]          mem_instruction;
    logic                 mem_memory_read, mem_memory_write, mem_register_write_enable;
    backend_pkg::wb_sel_e mem_wb_select;
    logic [2:0]           mem_funct3;
    logic [4:0]           mem_rd;

    execute_alu #(.XLEN(XLEN)) i_execute_alu (
        .alu_op(ex_alu_op), .alu_src_imm(ex_alu_src_imm),
        .rs1_data(ex_rs1_data), .rs2_data(ex_rs2_data), .imm(ex_imm), .pc(ex_pc),
        .alu_result(alu_result), .pc_plus_4(pc_plus_4)
    );

    ex_mem_register #(.XLEN(XLEN)) i_ex_mem_register (
        .clk(clk), .reset(reset), .stall(stall),
        .ex_pc(ex_pc), .ex_pc_plus_4(pc_plus_4), .ex_read_data2(ex_rs2_data),
        .ex_imm(ex_imm), .ex_csr_read_data(ex_csr_read_data),
        .ex_alu_result(alu_result), .ex_instruction(ex_instruction),
        .ex_memory_read(ex_memory_read), .ex_memory_write(ex_memory_write),
        .ex_register_write_enable(ex_register_write_enable),
        .ex_wb_select(ex_wb_select), .ex_funct3(ex_funct3), .ex_rd(ex_rd),
        .mem_pc(mem_pc), .mem_pc_plus_4(mem_pc_plus_4), .mem_read_data2(mem_read_data2),
        .mem_imm(mem_imm), .mem_csr_read_data(mem_csr_read_data),
        .mem_alu_result(mem_alu_result), .mem_instruction(mem_instruction),
        .mem_memory_read(mem_memory_read), .mem_memory_write(mem_memory_write),
        .mem_register_write_enable(mem_register_write_enable),
        .mem_wb_select(mem_wb_select), .mem_funct3(mem_funct3), .mem_rd(mem_rd)
    );

    load_store_unit #(.XLEN(XLEN), .DMEM_DEPTH(DMEM_DEPTH)) i_load_store_unit (
        .clk(clk), .reset(reset), .stall(stall),
        .memory_read(mem_memory_read), .memory_write(mem_memory_write),
        .funct3(mem_funct3), .address(mem_alu_result), .store_data(mem_read_data2),
        .load_data(load_data)
    );

    pipeline_control #(.LOAD_WAIT(LOAD_WAIT)) i_pipeline_control (
        .clk(clk), .reset(reset), .mem_memory_read(mem_memory_read), .stall(stall)
    );

    writeback_stage #(.XLEN(XLEN)) i_writeback_stage (
        .clk(clk), .reset(reset), .stall(stall),
        .mem_register_write_enable(mem_register_write_enable),
        .mem_wb_select(mem_wb_select), .mem_rd(mem_rd),
        .mem_alu_result(mem_alu_result), .load_data(load_data),
        .mem_pc_plus_4(mem_pc_plus_4), .mem_imm(mem_imm),
        .mem_csr_read_data(mem_csr_read_data), .mem_pc(mem_pc),
        .mem_instruction(mem_instruction),
        .wb_write_enable(wb_write_enable), .wb_rd(wb_rd), .wb_data(wb_data),
        .wb_pc(wb_pc), .wb_instruction(wb_instruction)
    );

endmodule

//--- hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage #(
    parameter int XLEN = 32
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 mem_register_write_enable,
    input  backend_pkg::wb_sel_e mem_wb_select,
    input  logic [4:0]           mem_rd,
    input  logic [XLEN-1:0]      mem_alu_result,
    input  logic [XLEN-1:0]      load_data,
    input  logic [XLEN-1:0]      mem_pc_plus_4,
    input  logic [XLEN-1:0]      mem_imm,
    input  logic [XLEN-1:0]      mem_csr_read_data,
    input  logic [XLEN-1:0]      mem_pc,
    input  logic [31:0]          mem_instruction,
    output logic                 wb_write_enable,
    output logic [4:0]           wb_rd,
    output logic [XLEN-1:0]      wb_data,
    output logic [XLEN-1:0]      wb_pc,
    output logic [31:0]          wb_instruction
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (mem_wb_select)
            backend_pkg::WB_MEM: result = load_data;
            backend_pkg::WB_PC4: result = mem_pc_plus_4;
            backend_pkg::WB_IMM: result = mem_imm;
            backend_pkg::WB_CSR: result = mem_csr_read_data;
            default:             result = mem_alu_result;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_write_enable <= 1'b0;
            wb_rd           <= 5'd0;
            wb_data         <= '0;
            wb_pc           <= '0;
            wb_instruction  <= 32'h0000_0013;
        end else begin
            // bubble while the load waits, x0 never written
            wb_write_enable <= !stall && mem_register_write_enable && (mem_rd != 5'd0);
            wb_rd           <= mem_rd;
            wb_data         <= result;
            wb_pc           <= mem_pc;
            wb_instruction  <= mem_instruction;
        end
    end

endmodule

//--- hw/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control #(
    parameter int LOAD_WAIT = 2
)(
    input  logic clk,
    input  logic reset,
    input  logic mem_memory_read,
    output logic stall
);

    localparam int CNT_W = $clog2(LOAD_WAIT + 1);
    localparam logic [CNT_W-1:0] WAIT_DONE = CNT_W'(LOAD_WAIT);

    backend_pkg::ctrl_state_e state, state_next;
    logic [CNT_W-1:0]         wait_count, wait_count_next;

    always_comb begin
        state_next      = state;
        wait_count_next = wait_count;
        stall           = 1'b0;
        case (state)
            backend_pkg::RUN: begin
                if (mem_memory_read) begin  // load just entered MEM
                    stall           = 1'b1;
                    state_next      = backend_pkg::LOAD_WAIT;
                    wait_count_next = CNT_W'(1);
                end
            end
            backend_pkg::LOAD_WAIT: begin
                if (wait_count == WAIT_DONE) begin
                    // data valid, load retires at the next edge
                    state_next      = backend_pkg::RUN;
                    wait_count_next = '0;
                end else begin
                    stall           = 1'b1;
                    wait_count_next = wait_count + 1'b1;
                end
            end
            default: state_next = backend_pkg::RUN;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= backend_pkg::RUN;
            wait_count <= '0;
        end else begin
            state      <= state_next;
            wait_count <= wait_count_next;
        end
    end

    a_stall_bounded: assert property (
        @(posedge clk) disable iff (reset)
        stall [*LOAD_WAIT] |=> !stall
    );

endmodule

//--- hw/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit #(
    parameter int XLEN       = 32,
    parameter int DMEM_DEPTH = 256
)(
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            memory_read,
    input  logic            memory_write,
    input  logic [2:0]      funct3,
    input  logic [XLEN-1:0] address,
    input  logic [XLEN-1:0] store_data,
    output logic [XLEN-1:0] load_data
);

    localparam int ADDR_W = $clog2(DMEM_DEPTH);
    localparam int NB     = XLEN / 8;  // byte lanes per word

    logic [XLEN-1:0]   mem [DMEM_DEPTH];
    logic [ADDR_W-1:0] word_index;
    logic [NB-1:0]     byte_en;
    logic [XLEN-1:0]   write_word;
    logic [XLEN-1:0]   read_word;
    logic [7:0]        read_byte;
    logic [15:0]       read_half;

    // word addressed, low bits pick the lane
    assign word_index = address[ADDR_W+1:2];

    // store lane steering
    always_comb begin
        case (funct3)
            backend_pkg::SB: begin
                write_word = {NB{store_data[7:0]}};
                byte_en    = NB'(1) << address[1:0];
            end
            backend_pkg::SH: begin
                write_word = {(NB/2){store_data[15:0]}};
                byte_en    = NB'(2'b11) << {address[1], 1'b0};
            end
            default: begin  // sw
                write_word = store_data;
                byte_en    = '1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (memory_write && !stall) begin
            for (int b = 0; b < NB; b++) begin
                if (byte_en[b]) begin
                    mem[word_index][8*b +: 8] <= write_word[8*b +: 8];
                end
            end
        end
    end

    assign read_word = mem[word_index];
    assign read_byte = read_word[8*address[1:0] +: 8];
    assign read_half = read_word[16*address[1] +: 16];

    // load extraction and extension
    always_comb begin
        if (!memory_read) begin
            load_data = '0;
        end else begin
            case (funct3)
                backend_pkg::LB:  load_data = {{(XLEN-8){read_byte[7]}}, read_byte};
                backend_pkg::LH:  load_data = {{(XLEN-16){read_half[15]}}, read_half};
                backend_pkg::LBU: load_data = {{(XLEN-8){1'b0}}, read_byte};
                backend_pkg::LHU: load_data = {{(XLEN-16){1'b0}}, read_half};
                default:          load_data = read_word;
            endcase
        end
    end

    // decode never marks an instruction as both load and store
    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (reset)
        !(memory_read && memory_write)
    );

endmodule

//--- hw/ex_mem_register.sv
`timescale 1ns/1ps

module ex_mem_register #(
    parameter int XLEN = 32
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,

    // from ID/EX and execute
    input  logic [XLEN-1:0]      ex_pc,
    input  logic [XLEN-1:0]      ex_pc_plus_4,
    input  logic [XLEN-1:0]      ex_read_data2,  // store data
    input  logic [XLEN-1:0]      ex_imm,
    input  logic [XLEN-1:0]      ex_csr_read_data,
    input  logic [XLEN-1:0]      ex_alu_result,
    input  logic [31:0]          ex_instruction,
    input  logic                 ex_memory_read,
    input  logic                 ex_memory_write,
    input  logic                 ex_register_write_enable,
    input  backend_pkg::wb_sel_e ex_wb_select,
    input  logic [2:0]           ex_funct3,
    input  logic [4:0]           ex_rd,

    // to memory stage
    output logic [XLEN-1:0]      mem_pc,
    output logic [XLEN-1:0]      mem_pc_plus_4,
    output logic [XLEN-1:0]      mem_read_data2,
    output logic [XLEN-1:0]      mem_imm,
    output logic [XLEN-1:0]      mem_csr_read_data,
    output logic [XLEN-1:0]      mem_alu_result,
    output logic [31:0]          mem_instruction,
    output logic                 mem_memory_read,
    output logic                 mem_memory_write,
    output logic                 mem_register_write_enable,
    output backend_pkg::wb_sel_e mem_wb_select,
    output logic [2:0]           mem_funct3,
    output logic [4:0]           mem_rd
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_pc                    <= '0;
            mem_pc_plus_4             <= '0;
            mem_read_data2            <= '0;
            mem_imm                   <= '0;
            mem_csr_read_data         <= '0;
            mem_alu_result            <= '0;
            mem_instruction           <= 32'h0000_0013;  // addi x0, x0, 0
            mem_memory_read           <= 1'b0;
            mem_memory_write          <= 1'b0;
            mem_register_write_enable <= 1'b0;
            mem_wb_select             <= backend_pkg::WB_ALU;
            mem_funct3                <= 3'b000;
            mem_rd                    <= 5'd0;
        end else if (!stall) begin
            mem_pc                    <= ex_pc;
            mem_pc_plus_4             <= ex_pc_plus_4;
            mem_read_data2            <= ex_read_data2;
            mem_imm                   <= ex_imm;
            mem_csr_read_data         <= ex_csr_read_data;
            mem_alu_result            <= ex_alu_result;
            mem_instruction           <= ex_instruction;
            mem_memory_read           <= ex_memory_read;
            mem_memory_write          <= ex_memory_write;
            mem_register_write_enable <= ex_register_write_enable;
            mem_wb_select             <= ex_wb_select;
            mem_funct3                <= ex_funct3;
            mem_rd                    <= ex_rd;
        end
    end

    // a stalled edge must leave the whole MEM slot untouched
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> $stable({mem_pc, mem_pc_plus_4, mem_read_data2, mem_imm,
                           mem_csr_read_data, mem_alu_result, mem_instruction,
                           mem_memory_read, mem_memory_write,
                           mem_register_write_enable, mem_wb_select,
                           mem_funct3, mem_rd})
    );

endmodule

//--- hw/execute_alu.sv
`timescale 1ns/1ps

module execute_alu #(
    parameter int XLEN = 32
)(
    input  backend_pkg::alu_op_e alu_op,
    input  logic                 alu_src_imm,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,
    input  logic [XLEN-1:0]      imm,
    input  logic [XLEN-1:0]      pc,
    output logic [XLEN-1:0]      alu_result,
    output logic [XLEN-1:0]      pc_plus_4
);

    logic [XLEN-1:0] operand_b;
    logic [4:0]      shamt;

    assign operand_b = alu_src_imm ? imm : rs2_data;
    assign shamt     = operand_b[4:0];  // rv32 shift amount

    // link address for jal/jalr
    assign pc_plus_4 = pc + XLEN'(4);

    always_comb begin
        case (alu_op)
            backend_pkg::ADD:    alu_result = rs1_data + operand_b;
            backend_pkg::SUB:    alu_result = rs1_data - operand_b;
            backend_pkg::SLL:    alu_result = rs1_data << shamt;
            backend_pkg::SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(operand_b)};
            end
            backend_pkg::SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, rs1_data < operand_b};
            end
            backend_pkg::XOR:    alu_result = rs1_data ^ operand_b;
            backend_pkg::SRL:    alu_result = rs1_data >> shamt;
            backend_pkg::SRA:    alu_result = $unsigned($signed(rs1_data) >>> shamt);
            backend_pkg::OR:     alu_result = rs1_data | operand_b;
            backend_pkg::AND:    alu_result = rs1_data & operand_b;
            backend_pkg::PASS_B: alu_result = operand_b;
            default:             alu_result = '0;
        endcase
    end

endmodule

//--- hw/backend_pkg.sv
package backend_pkg;

    // alu operation, decoded in ID
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10  // lui
    } alu_op_e;

    // register file write data source
    typedef enum logic [2:0] {
        WB_ALU = 3'd0,
        WB_MEM = 3'd1,
        WB_PC4 = 3'd2,
        WB_IMM = 3'd3,
        WB_CSR = 3'd4
    } wb_sel_e;

    typedef enum logic {
        RUN       = 1'b0,
        LOAD_WAIT = 1'b1  // load counting access time
    } ctrl_state_e;

    // funct3 width codes
    localparam logic [2:0] LB  = 3'b000;
    localparam logic [2:0] LH  = 3'b001;
    localparam logic [2:0] LW  = 3'b010;
    localparam logic [2:0] LBU = 3'b100;
    localparam logic [2:0] LHU = 3'b101;
    localparam logic [2:0] SB  = 3'b000;
    localparam logic [2:0] SH  = 3'b001;
    localparam logic [2:0] SW  = 3'b010;

endpackage
